// File: vlog.f
dtlb_pkg.sv
dtlb_entry.sv
dtlb_ctrl.sv
dtlb_resolve.sv
dtlb_mshr.sv
dtlb_top.sv
tb_clk_gen.sv
tb_dtlb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the data TLB testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module tb_dtlb; then
  echo "Verilator build failed"
  exit 1
fi

if ! out="$(./obj_dir/Vtb_dtlb 2>&1)"; then
  echo "$out"
  echo "Simulation returned an error status"
  exit 1
fi

echo "$out"

if grep -qx "Result: PASSED" <<< "$out"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// File: tb_dtlb.sv
/* Self-checking testbench of the data TLB. Drives LSQ requests, plays the
   second-level TLB and checks answers, wake-ups, flushes and back-pressure. */
`timescale 1ns/100ps

module tb_dtlb;
  import dtlb_pkg::*;

  localparam int WAIT_LIMIT = 50;
  // Permission bits ordered {g, u, r, w, x, d}
  localparam logic [5:0] PERM_RWD   = 6'b001101;
  localparam logic [5:0] PERM_RO    = 6'b001001;
  localparam logic [5:0] PERM_CLEAN = 6'b001100;
  localparam logic [5:0] PERM_USER  = 6'b011101;
  localparam logic [5:0] PERM_XONLY = 6'b000010;
  localparam logic [5:0] PERM_GLOB  = 6'b101101;

  logic clk_i, rst_ni;
  logic req_valid_i, req_ready_o, req_store_i;
  logic [VPN_W-1:0] req_vpn_i;
  logic ans_valid_o, ans_fault_o;
  logic [PPN_W-1:0] ans_ppn_o;
  logic wup_valid_o, wup_fault_o;
  logic [VPN_W-1:0] wup_vpn_o;
  logic [PPN_W-1:0] wup_ppn_o;
  logic l2_req_valid_o, l2_req_ready_i;
  logic [VPN_W-1:0] l2_req_vpn_o, l2_ans_vpn_i;
  logic l2_ans_valid_i, l2_ans_fault_i;
  logic [PPN_W-1:0] l2_ans_ppn_i;
  page_e l2_ans_page_i;
  logic l2_ans_g_i, l2_ans_u_i, l2_ans_r_i, l2_ans_w_i, l2_ans_x_i, l2_ans_d_i;
  priv_e priv_i;
  logic sum_i, mxr_i;
  logic [ASID_W-1:0] asid_i, flush_asid_i;
  flush_e flush_type_i;
  logic [VPN_W-1:0] flush_page_i;
  logic clr_mshr_i;
  int seed = 32'hecc7_2d0e;
  logic [VPN_W-1:0] va, vg, vm, vro, vcl, vu, vx, vgl, vf;
  logic [VPN_W-1:0] vb [5];
  logic l2_stalled;

  tb_clk_gen #(.PERIOD(4ns), .RST_CYCLES(3)) u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  dtlb_top u_dtlb_top (.*);

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else stop_with_error($sformatf("FAILED at %0t: %s is %0h, expected %0h",
                                     $time, name, got, exp));
  endtask

  task automatic report_wrong_bit(input string name, input logic exp);
    stop_with_error($sformatf("FAILED at %0t: %s is %0b, expected %0b",
                              $time, name, !exp, exp));
  endtask

  // Responder rule is fixed upper bits and the VPN scrambled by a constant
  function automatic logic [PPN_W-1:0] ppn_of(input logic [VPN_W-1:0] vpn);
    return {17'h1234, vpn ^ 27'h2a5_5a5a};
  endfunction

  // Top level holds the index so test pages never overlap by chance
  function automatic logic [VPN_W-1:0] fresh_vpn(input int idx);
    logic [31:0] r;
    r = $random(seed);
    return {9'(idx), r[17:0]};
  endfunction

  // Reset comes from the clock module and is polled at each edge
  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst_ni !== 1'b1) begin
      n++;
      if (n > WAIT_LIMIT) stop_with_error("Timeout while waiting for reset release");
      @(posedge clk_i);
    end
  endtask

  // Every task starts and ends 1 ns after a rising edge
  task automatic lookup(input logic [VPN_W-1:0] vpn, input logic store,
                        input logic exp_hit, input logic exp_fault);
    int n;
    n = 0;
    req_valid_i = 1'b1;
    req_vpn_i   = vpn;
    req_store_i = store;
    @(negedge clk_i);
    while (!req_ready_o) begin
      n++;
      if (n > WAIT_LIMIT) stop_with_error("Timeout while waiting for req_ready_o");
      @(negedge clk_i);
    end
    expect_eq("ans_valid_o", 64'(ans_valid_o), 64'(exp_hit));
    if (exp_hit) begin
      expect_eq("ans_ppn_o", 64'(ans_ppn_o), 64'(ppn_of(vpn_base(vpn))));
      expect_eq("ans_fault_o", 64'(ans_fault_o), 64'(exp_fault));
    end
    @(posedge clk_i);
    #1 req_valid_i = 1'b0;
    req_store_i = 1'b0;
  endtask

  // Maps a request VPN to the VPN the page was filled with
  function automatic logic [VPN_W-1:0] vpn_base(input logic [VPN_W-1:0] vpn);
    if (vpn[26:18] == vg[26:18]) return vg;
    if (vpn[26:9] == vm[26:9]) return vm;
    return vpn;
  endfunction

  // Plays the second-level TLB for one pending miss and stalls it first
  task automatic serve_miss(input logic [VPN_W-1:0] vpn, input page_e page,
                            input logic [5:0] perm, input logic fault,
                            input logic exp_next);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!l2_req_valid_o) begin
      n++;
      if (n > WAIT_LIMIT) stop_with_error("Timeout while waiting for l2_req_valid_o");
      @(negedge clk_i);
    end
    expect_eq("l2_req_vpn_o", 64'(l2_req_vpn_o), 64'(vpn));
    repeat (3) @(posedge clk_i);
    #1 l2_req_ready_i = 1'b1;
    @(negedge clk_i);
    expect_eq("l2_req_valid_o", 64'(l2_req_valid_o), 64'd1);
    @(posedge clk_i);
    #1 l2_req_ready_i = 1'b0;
    l2_ans_valid_i = 1'b1;
    l2_ans_vpn_i   = vpn;
    l2_ans_ppn_i   = ppn_of(vpn);
    l2_ans_page_i  = page;
    l2_ans_fault_i = fault;
    {l2_ans_g_i, l2_ans_u_i, l2_ans_r_i, l2_ans_w_i, l2_ans_x_i, l2_ans_d_i} = perm;
    @(negedge clk_i);
    expect_eq("wup_valid_o", 64'(wup_valid_o), 64'd1);
    expect_eq("wup_vpn_o", 64'(wup_vpn_o), 64'(vpn));
    expect_eq("wup_ppn_o", 64'(wup_ppn_o), 64'(ppn_of(vpn)));
    expect_eq("wup_fault_o", 64'(wup_fault_o), 64'(fault));
    expect_eq("req_ready_o", 64'(req_ready_o), 64'd0);
    // Only other pending pages may follow, never a merged miss again
    expect_eq("l2_req_valid_o", 64'(l2_req_valid_o), 64'(exp_next));
    @(posedge clk_i);
    #1 l2_ans_valid_i = 1'b0;
  endtask

  task automatic fill_page(input logic [VPN_W-1:0] vpn, input page_e page,
                           input logic [5:0] perm);
    lookup(vpn, 1'b0, 1'b0, 1'b0);
    serve_miss(vpn, page, perm, 1'b0, 1'b0);
  endtask

  task automatic clear_mshr();
    clr_mshr_i = 1'b1;
    @(posedge clk_i);
    #1 clr_mshr_i = 1'b0;
    @(negedge clk_i);
    expect_eq("l2_req_valid_o", 64'(l2_req_valid_o), 64'd0);
    expect_eq("req_ready_o", 64'(req_ready_o), 64'd1);
    @(posedge clk_i);
    #1;
  endtask

  task automatic do_flush(input flush_e kind, input logic [ASID_W-1:0] asid,
                          input logic [VPN_W-1:0] page);
    flush_type_i = kind;
    flush_asid_i = asid;
    flush_page_i = page;
    @(negedge clk_i);
    expect_eq("req_ready_o", 64'(req_ready_o), 64'd0);
    @(posedge clk_i);
    #1 flush_type_i = FLUSH_NONE;
  endtask

  // Presented request that nothing may retire in this cycle
  assign l2_stalled = l2_req_valid_o && !l2_req_ready_i && !clr_mshr_i && !l2_ans_valid_i;

  // Checks that hold on every cycle out of reset
  a_flush_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (flush_type_i != FLUSH_NONE) |-> !req_ready_o)
    else report_wrong_bit("req_ready_o", 1'b0);
  a_ans_on_transfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ans_valid_o |-> (req_valid_i && req_ready_o))
    else report_wrong_bit("ans_valid_o", 1'b0);
  a_wup_on_answer: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wup_valid_o |-> l2_ans_valid_i)
    else report_wrong_bit("wup_valid_o", 1'b0);
  a_l2_hold_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      l2_stalled |=> l2_req_valid_o)
    else report_wrong_bit("l2_req_valid_o", 1'b1);
  a_l2_hold_vpn: assert property (@(posedge clk_i) disable iff (!rst_ni)
      l2_stalled |=> $stable(l2_req_vpn_o))
    else stop_with_error("Second-level request VPN changed while stalled");
  a_clr_empties: assert property (@(posedge clk_i) disable iff (!rst_ni)
      clr_mshr_i |=> !l2_req_valid_o)
    else report_wrong_bit("l2_req_valid_o", 1'b0);

  initial begin
    req_valid_i = 1'b0;
    req_vpn_i = '0;
    req_store_i = 1'b0;
    l2_req_ready_i = 1'b0;
    l2_ans_valid_i = 1'b0;
    l2_ans_vpn_i = '0;
    l2_ans_ppn_i = '0;
    l2_ans_page_i = PAGE_KIBI;
    l2_ans_fault_i = 1'b0;
    {l2_ans_g_i, l2_ans_u_i, l2_ans_r_i, l2_ans_w_i, l2_ans_x_i, l2_ans_d_i} = '0;
    priv_i = PRIV_S;
    sum_i = 1'b0;
    mxr_i = 1'b0;
    asid_i = 16'h0001;
    flush_type_i = FLUSH_NONE;
    flush_asid_i = '0;
    flush_page_i = '0;
    clr_mshr_i = 1'b0;
    va = fresh_vpn(1);
    vg = fresh_vpn(2);
    vm = fresh_vpn(3);
    vro = fresh_vpn(4);
    vcl = fresh_vpn(5);
    vu = fresh_vpn(6);
    vx = fresh_vpn(7);
    vgl = fresh_vpn(8);
    vf = fresh_vpn(9);
    for (int k = 0; k < 5; k++) vb[k] = fresh_vpn(10 + k);

    wait_reset_release();
    @(posedge clk_i);
    #1;
    @(negedge clk_i);
    expect_eq("ans_valid_o", 64'(ans_valid_o), 64'd0);
    expect_eq("wup_valid_o", 64'(wup_valid_o), 64'd0);
    expect_eq("l2_req_valid_o", 64'(l2_req_valid_o), 64'd0);
    expect_eq("req_ready_o", 64'(req_ready_o), 64'd1);
    @(posedge clk_i);
    #1;

    // Miss, merged second miss, single request, fill and retry
    lookup(va, 1'b0, 1'b0, 1'b0);
    @(negedge clk_i);
    expect_eq("l2_req_valid_o", 64'(l2_req_valid_o), 64'd1);
    expect_eq("l2_req_vpn_o", 64'(l2_req_vpn_o), 64'(va));
    @(posedge clk_i);
    #1;
    lookup(va, 1'b0, 1'b0, 1'b0);
    serve_miss(va, PAGE_KIBI, PERM_RWD, 1'b0, 1'b0);
    @(negedge clk_i);
    expect_eq("l2_req_valid_o", 64'(l2_req_valid_o), 64'd0);
    @(posedge clk_i);
    #1;
    lookup(va, 1'b0, 1'b1, 1'b0);

    // Page sizes
    fill_page(vg, PAGE_GIBI, PERM_RWD);
    fill_page(vm, PAGE_MEBI, PERM_RWD);
    lookup(vg ^ 27'h3_ffff, 1'b0, 1'b1, 1'b0);
    lookup(vm ^ 27'h1ff, 1'b0, 1'b1, 1'b0);
    lookup({9'd30, vg[17:0]}, 1'b0, 1'b0, 1'b0);
    clear_mshr();
    lookup(vm ^ 27'h200, 1'b0, 1'b0, 1'b0);
    clear_mshr();

    // Permissions
    fill_page(vro, PAGE_KIBI, PERM_RO);
    fill_page(vcl, PAGE_KIBI, PERM_CLEAN);
    fill_page(vu, PAGE_KIBI, PERM_USER);
    fill_page(vx, PAGE_KIBI, PERM_XONLY);
    lookup(vro, 1'b1, 1'b1, 1'b1);
    lookup(vro, 1'b0, 1'b1, 1'b0);
    lookup(vcl, 1'b1, 1'b1, 1'b1);
    priv_i = PRIV_U;
    lookup(va, 1'b0, 1'b1, 1'b1);
    lookup(vu, 1'b0, 1'b1, 1'b0);
    priv_i = PRIV_S;
    lookup(vu, 1'b0, 1'b1, 1'b1);
    sum_i = 1'b1;
    lookup(vu, 1'b0, 1'b1, 1'b0);
    sum_i = 1'b0;
    lookup(vx, 1'b0, 1'b1, 1'b1);
    mxr_i = 1'b1;
    lookup(vx, 1'b0, 1'b1, 1'b0);
    mxr_i = 1'b0;
    lookup(vf, 1'b0, 1'b0, 1'b0);
    serve_miss(vf, PAGE_KIBI, PERM_RWD, 1'b1, 1'b0);
    lookup(vf, 1'b0, 1'b0, 1'b0);
    clear_mshr();

    // Flushes
    fill_page(vgl, PAGE_KIBI, PERM_GLOB);
    do_flush(FLUSH_PAGE, 16'h0001, vm ^ 27'h0a5);
    lookup(vm, 1'b0, 1'b0, 1'b0);
    clear_mshr();
    lookup(va, 1'b0, 1'b1, 1'b0);
    do_flush(FLUSH_ASID, 16'h0001, '0);
    lookup(va, 1'b0, 1'b0, 1'b0);
    clear_mshr();
    lookup(vgl, 1'b0, 1'b1, 1'b0);
    do_flush(FLUSH_ALL, '0, '0);
    lookup(vgl, 1'b0, 1'b0, 1'b0);
    clear_mshr();

    // MSHR back-pressure
    for (int k = 0; k < MSHR_ENTRIES; k++) lookup(vb[k], 1'b0, 1'b0, 1'b0);
    @(negedge clk_i);
    expect_eq("req_ready_o", 64'(req_ready_o), 64'd0);
    @(posedge clk_i);
    #1;
    serve_miss(vb[0], PAGE_KIBI, PERM_RWD, 1'b0, 1'b1);
    @(negedge clk_i);
    expect_eq("req_ready_o", 64'(req_ready_o), 64'd1);
    @(posedge clk_i);
    #1;
    lookup(vb[4], 1'b0, 1'b0, 1'b0);
    @(negedge clk_i);
    expect_eq("req_ready_o", 64'(req_ready_o), 64'd0);
    @(posedge clk_i);
    #1;
    clear_mshr();

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
/* Testbench clock and reset source for the data TLB.
   Free-running clock, reset held low for a few cycles after start. */
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter realtime PERIOD     = 4ns,
  parameter int      RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release reset just after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// File: dtlb_top.sv
/* Sv39 first-level data TLB, fully associative with mixed page sizes.
   Connects the arbiter, the entry array, the resolver and the MSHR. */
`timescale 1ns/100ps

module dtlb_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // LSQ request and answer
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  logic [dtlb_pkg::VPN_W-1:0]  req_vpn_i,
  input  logic                        req_store_i,
  output logic                        ans_valid_o,
  output logic [dtlb_pkg::PPN_W-1:0]  ans_ppn_o,
  output logic                        ans_fault_o,
  // Wake-up of waiting loads and stores
  output logic                        wup_valid_o,
  output logic [dtlb_pkg::VPN_W-1:0]  wup_vpn_o,
  output logic                        wup_fault_o,
  output logic [dtlb_pkg::PPN_W-1:0]  wup_ppn_o,
  // Second-level TLB request and answer
  output logic                        l2_req_valid_o,
  input  logic                        l2_req_ready_i,
  output logic [dtlb_pkg::VPN_W-1:0]  l2_req_vpn_o,
  input  logic                        l2_ans_valid_i,
  input  logic [dtlb_pkg::VPN_W-1:0]  l2_ans_vpn_i,
  input  logic [dtlb_pkg::PPN_W-1:0]  l2_ans_ppn_i,
  input  dtlb_pkg::page_e             l2_ans_page_i,
  input  logic                        l2_ans_fault_i,
  input  logic                        l2_ans_g_i,
  input  logic                        l2_ans_u_i,
  input  logic                        l2_ans_r_i,
  input  logic                        l2_ans_w_i,
  input  logic                        l2_ans_x_i,
  input  logic                        l2_ans_d_i,
  // CSR state
  input  dtlb_pkg::priv_e             priv_i,
  input  logic                        sum_i,
  input  logic                        mxr_i,
  input  logic [dtlb_pkg::ASID_W-1:0] asid_i,
  // Flush and mispredict
  input  dtlb_pkg::flush_e            flush_type_i,
  input  logic [dtlb_pkg::ASID_W-1:0] flush_asid_i,
  input  logic [dtlb_pkg::VPN_W-1:0]  flush_page_i,
  input  logic                        clr_mshr_i
);
  import dtlb_pkg::*;

  tlb_op_e                           op;
  logic                              fill_en, miss;
  logic                              mshr_full, mshr_pend, mshr_ans_match;
  logic [TLB_ENTRIES-1:0]            hit_vec, fault_vec, valid_vec, write_vec;
  logic [TLB_ENTRIES-1:0][PPN_W-1:0] ppn_vec;

  // Wake-up payload is the raw second-level answer
  assign wup_vpn_o   = l2_ans_vpn_i;
  assign wup_ppn_o   = l2_ans_ppn_i;
  assign wup_fault_o = l2_ans_fault_i;

  dtlb_ctrl u_ctrl (
    .req_valid_i      (req_valid_i),
    .flush_type_i     (flush_type_i),
    .l2_ans_valid_i   (l2_ans_valid_i),
    .l2_ans_fault_i   (l2_ans_fault_i),
    .mshr_full_i      (mshr_full),
    .mshr_ans_match_i (mshr_ans_match),
    .op_o             (op),
    .req_ready_o      (req_ready_o),
    .fill_en_o        (fill_en),
    .wup_valid_o      (wup_valid_o)
  );

  for (genvar k = 0; k < TLB_ENTRIES; k++) begin : g_entry
    dtlb_entry u_entry (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .op_i         (op),
      .flush_type_i (flush_type_i),
      .flush_asid_i (flush_asid_i),
      .flush_page_i (flush_page_i),
      .write_i      (write_vec[k]),
      .fill_vpn_i   (l2_ans_vpn_i),
      .fill_ppn_i   (l2_ans_ppn_i),
      .fill_page_i  (l2_ans_page_i),
      .fill_g_i     (l2_ans_g_i),
      .fill_u_i     (l2_ans_u_i),
      .fill_r_i     (l2_ans_r_i),
      .fill_w_i     (l2_ans_w_i),
      .fill_x_i     (l2_ans_x_i),
      .fill_d_i     (l2_ans_d_i),
      .asid_i       (asid_i),
      .req_vpn_i    (req_vpn_i),
      .req_store_i  (req_store_i),
      .priv_i       (priv_i),
      .sum_i        (sum_i),
      .mxr_i        (mxr_i),
      .valid_o      (valid_vec[k]),
      .hit_o        (hit_vec[k]),
      .fault_o      (fault_vec[k]),
      .ppn_o        (ppn_vec[k])
    );
  end

  dtlb_resolve u_resolve (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_i        (op),
    .fill_en_i   (fill_en),
    .pend_i      (mshr_pend),
    .hit_i       (hit_vec),
    .fault_i     (fault_vec),
    .valid_i     (valid_vec),
    .ppn_i       (ppn_vec),
    .ans_valid_o (ans_valid_o),
    .ans_ppn_o   (ans_ppn_o),
    .ans_fault_o (ans_fault_o),
    .miss_o      (miss),
    .write_o     (write_vec)
  );

  dtlb_mshr u_mshr (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clr_i          (clr_mshr_i),
    .alloc_i        (miss),
    .req_vpn_i      (req_vpn_i),
    .l2_ans_valid_i (l2_ans_valid_i),
    .l2_ans_vpn_i   (l2_ans_vpn_i),
    .l2_ans_page_i  (l2_ans_page_i),
    .l2_req_ready_i (l2_req_ready_i),
    .full_o         (mshr_full),
    .pend_o         (mshr_pend),
    .ans_match_o    (mshr_ans_match),
    .l2_req_valid_o (l2_req_valid_o),
    .l2_req_vpn_o   (l2_req_vpn_o)
  );

endmodule

// File: dtlb_mshr.sv
/* Pending-miss table of the data TLB. Sends each missed page once to the
   second-level TLB and retires entries matched by its answers. */
`timescale 1ns/100ps

module dtlb_mshr (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clr_i,
  input  logic                        alloc_i,
  input  logic [dtlb_pkg::VPN_W-1:0]  req_vpn_i,
  input  logic                        l2_ans_valid_i,
  input  logic [dtlb_pkg::VPN_W-1:0]  l2_ans_vpn_i,
  input  dtlb_pkg::page_e             l2_ans_page_i,
  input  logic                        l2_req_ready_i,
  output logic                        full_o,
  output logic                        pend_o,
  output logic                        ans_match_o,
  output logic                        l2_req_valid_o,
  output logic [dtlb_pkg::VPN_W-1:0]  l2_req_vpn_o
);
  import dtlb_pkg::*;

  logic [VPN_W-1:0]      vpn_q [MSHR_ENTRIES];
  logic [MSHR_ENTRIES-1:0] valid_q, wait_q;
  logic [MSHR_ENTRIES-1:0] rm_vec, pend_vec;
  logic [MSHR_IDX_W-1:0] free_idx, ready_idx, sel_idx, lock_idx_q;
  logic                  lock_q;
  logic                  issue;

  // Answer matches at the answer's page size, lookups match exactly
  always_comb begin
    for (int k = 0; k < MSHR_ENTRIES; k++) begin
      unique case (l2_ans_page_i)
        PAGE_GIBI: rm_vec[k] = vpn_q[k][VPN_W-1:2*LEVEL_W] == l2_ans_vpn_i[VPN_W-1:2*LEVEL_W];
        PAGE_MEBI: rm_vec[k] = vpn_q[k][VPN_W-1:LEVEL_W] == l2_ans_vpn_i[VPN_W-1:LEVEL_W];
        default:   rm_vec[k] = vpn_q[k] == l2_ans_vpn_i;
      endcase
      rm_vec[k]   = rm_vec[k] && valid_q[k] && l2_ans_valid_i;
      pend_vec[k] = valid_q[k] && (vpn_q[k] == req_vpn_i);
    end
  end

  assign ans_match_o = |rm_vec;
  assign pend_o      = |pend_vec;
  assign full_o      = &valid_q;

  // Priority encoders, lowest index first
  always_comb begin
    free_idx  = '0;
    ready_idx = '0;
    for (int k = MSHR_ENTRIES - 1; k >= 0; k--) begin
      if (!valid_q[k]) free_idx = MSHR_IDX_W'(k);
      if (valid_q[k] && !wait_q[k]) ready_idx = MSHR_IDX_W'(k);
    end
  end

  // Hold the presented entry while the second level stalls
  assign sel_idx        = lock_q ? lock_idx_q : ready_idx;
  assign l2_req_valid_o = valid_q[sel_idx] && !wait_q[sel_idx];
  assign l2_req_vpn_o   = vpn_q[sel_idx];
  assign issue          = l2_req_valid_o && l2_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      wait_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (clr_i) begin
      valid_q <= '0;
      wait_q  <= '0;
      lock_q  <= 1'b0;
    end else begin
      lock_q     <= l2_req_valid_o && !l2_req_ready_i;
      lock_idx_q <= sel_idx;
      for (int k = 0; k < MSHR_ENTRIES; k++) begin
        if (rm_vec[k]) begin
          valid_q[k] <= 1'b0;
          wait_q[k]  <= 1'b0;
        end else if (issue && sel_idx == MSHR_IDX_W'(k)) begin
          // Requested once, now only the answer can retire it
          wait_q[k] <= 1'b1;
        end else if (alloc_i && !full_o && free_idx == MSHR_IDX_W'(k)) begin
          valid_q[k] <= 1'b1;
          wait_q[k]  <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i && !full_o) vpn_q[free_idx] <= req_vpn_i;
  end

endmodule

// File: dtlb_resolve.sv
/* Collects the per-entry hit and fault bits into the LSQ answer and flags
   misses. On fills it picks the victim entry and drives the one-hot write. */
`timescale 1ns/100ps

module dtlb_resolve (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  dtlb_pkg::tlb_op_e                                  op_i,
  input  logic                                               fill_en_i,
  input  logic                                               pend_i,
  input  logic [dtlb_pkg::TLB_ENTRIES-1:0]                   hit_i,
  input  logic [dtlb_pkg::TLB_ENTRIES-1:0]                   fault_i,
  input  logic [dtlb_pkg::TLB_ENTRIES-1:0]                   valid_i,
  input  logic [dtlb_pkg::TLB_ENTRIES-1:0][dtlb_pkg::PPN_W-1:0] ppn_i,
  output logic                                               ans_valid_o,
  output logic [dtlb_pkg::PPN_W-1:0]                         ans_ppn_o,
  output logic                                               ans_fault_o,
  output logic                                               miss_o,
  output logic [dtlb_pkg::TLB_ENTRIES-1:0]                   write_o
);
  import dtlb_pkg::*;

  logic [TLB_IDX_W-1:0] rr_q;
  logic [TLB_IDX_W-1:0] victim_idx;
  logic                 all_valid;
  logic                 lookup;

  assign lookup      = (op_i == OP_LOOKUP);
  assign ans_valid_o = lookup && |hit_i;
  // Misses already in flight are merged, not allocated twice
  assign miss_o      = lookup && !(|hit_i) && !pend_i;

  // Lowest hit index wins if overlapping pages ever both match
  always_comb begin
    ans_ppn_o   = '0;
    ans_fault_o = 1'b0;
    for (int k = TLB_ENTRIES - 1; k >= 0; k--) begin
      if (hit_i[k]) begin
        ans_ppn_o   = ppn_i[k];
        ans_fault_o = fault_i[k];
      end
    end
  end

  // Victim: lowest free way, round-robin once the array is full
  assign all_valid = &valid_i;
  always_comb begin
    victim_idx = rr_q;
    for (int k = TLB_ENTRIES - 1; k >= 0; k--) begin
      if (!valid_i[k]) victim_idx = TLB_IDX_W'(k);
    end
  end

  always_comb begin
    write_o = '0;
    if (fill_en_i) write_o[victim_idx] = 1'b1;
  end

  // Pointer moves only when a live translation gets evicted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (fill_en_i && all_valid) begin
      rr_q <= rr_q + TLB_IDX_W'(1);
    end
  end

endmodule

// File: dtlb_ctrl.sv
/* Per-cycle arbiter of the data TLB. Grants one of flush, fill or lookup,
   drives the LSQ ready and decides wake-up and TLB write on fills. */
`timescale 1ns/100ps

module dtlb_ctrl (
  input  logic              req_valid_i,
  input  dtlb_pkg::flush_e  flush_type_i,
  input  logic              l2_ans_valid_i,
  input  logic              l2_ans_fault_i,
  input  logic              mshr_full_i,
  input  logic              mshr_ans_match_i,
  output dtlb_pkg::tlb_op_e op_o,
  output logic              req_ready_o,
  output logic              fill_en_o,
  output logic              wup_valid_o
);
  import dtlb_pkg::*;

  logic flush_req;
  logic fill_req;
  logic lookup_req;

  // Pending flush always goes first
  assign flush_req = (flush_type_i != FLUSH_NONE);

  // Second-level answer has no ready, so it beats any lookup
  assign fill_req = !flush_req && l2_ans_valid_i;

  // Lookup only when a miss could still be stored
  assign lookup_req = !flush_req && !l2_ans_valid_i && !mshr_full_i && req_valid_i;

  always_comb begin
    if (flush_req) begin
      op_o = OP_FLUSH;
    end else if (fill_req) begin
      op_o = OP_FILL;
    end else if (lookup_req) begin
      op_o = OP_LOOKUP;
    end else begin
      op_o = OP_IDLE;
    end
  end

  // Ready whenever a valid request would be granted the lookup slot
  assign req_ready_o = (op_o == OP_LOOKUP) || (op_o == OP_IDLE && !mshr_full_i);

  // Wake-up only for answers that some pending miss asked for
  assign wup_valid_o = (op_o == OP_FILL) && mshr_ans_match_i;

  // Faulting translations are reported but never cached
  assign fill_en_o = wup_valid_o && !l2_ans_fault_i;

endmodule

// File: dtlb_entry.sv
/* One fully associative TLB entry: translation storage, VPN and ASID match,
   permission check and flush match. Instantiated once per way by the top. */
`timescale 1ns/100ps

module dtlb_entry (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  dtlb_pkg::tlb_op_e             op_i,
  input  dtlb_pkg::flush_e              flush_type_i,
  input  logic [dtlb_pkg::ASID_W-1:0]   flush_asid_i,
  input  logic [dtlb_pkg::VPN_W-1:0]    flush_page_i,
  input  logic                          write_i,
  input  logic [dtlb_pkg::VPN_W-1:0]    fill_vpn_i,
  input  logic [dtlb_pkg::PPN_W-1:0]    fill_ppn_i,
  input  dtlb_pkg::page_e               fill_page_i,
  input  logic                          fill_g_i,
  input  logic                          fill_u_i,
  input  logic                          fill_r_i,
  input  logic                          fill_w_i,
  input  logic                          fill_x_i,
  input  logic                          fill_d_i,
  input  logic [dtlb_pkg::ASID_W-1:0]   asid_i,
  input  logic [dtlb_pkg::VPN_W-1:0]    req_vpn_i,
  input  logic                          req_store_i,
  input  dtlb_pkg::priv_e               priv_i,
  input  logic                          sum_i,
  input  logic                          mxr_i,
  output logic                          valid_o,
  output logic                          hit_o,
  output logic                          fault_o,
  output logic [dtlb_pkg::PPN_W-1:0]    ppn_o
);
  import dtlb_pkg::*;

  logic              valid_q;
  logic [VPN_W-1:0]  vpn_q;
  logic [PPN_W-1:0]  ppn_q;
  logic [ASID_W-1:0] asid_q;
  logic              g_q, u_q, r_q, w_q, x_q, d_q;
  // Page size kept as two flags, both low for a 4 KiB page
  logic              mebi_q, gibi_q;
  logic              req_match, flush_match, asid_ok, flush_hit;

  // Compare at the entry's own page size, upper levels always count
  assign req_match = (req_vpn_i[VPN_W-1:2*LEVEL_W] == vpn_q[VPN_W-1:2*LEVEL_W])
      && (gibi_q || req_vpn_i[2*LEVEL_W-1:LEVEL_W] == vpn_q[2*LEVEL_W-1:LEVEL_W])
      && (gibi_q || mebi_q || req_vpn_i[LEVEL_W-1:0] == vpn_q[LEVEL_W-1:0]);
  assign flush_match = (flush_page_i[VPN_W-1:2*LEVEL_W] == vpn_q[VPN_W-1:2*LEVEL_W])
      && (gibi_q || flush_page_i[2*LEVEL_W-1:LEVEL_W] == vpn_q[2*LEVEL_W-1:LEVEL_W])
      && (gibi_q || mebi_q || flush_page_i[LEVEL_W-1:0] == vpn_q[LEVEL_W-1:0]);

  // Global pages ignore the current ASID
  assign asid_ok = g_q || (asid_q == asid_i);
  assign hit_o   = (op_i == OP_LOOKUP) && valid_q && asid_ok && req_match;

  always_comb begin
    fault_o = 1'b0;
    // Not readable, MXR only lets executable pages through
    if (!r_q && !(mxr_i && x_q))                        fault_o = 1'b1;
    // Store to a read-only page
    else if (req_store_i && !w_q)                       fault_o = 1'b1;
    // Store to a clean page, dirty bit must be set by the walker
    else if (req_store_i && !d_q)                       fault_o = 1'b1;
    // Supervisor on a user page needs SUM
    else if (u_q && priv_i == PRIV_S && !sum_i)         fault_o = 1'b1;
    // User mode never reaches supervisor pages
    else if (!u_q && priv_i == PRIV_U)                  fault_o = 1'b1;
    if (!hit_o) fault_o = 1'b0;
  end

  always_comb begin
    unique case (flush_type_i)
      FLUSH_ALL:  flush_hit = 1'b1;
      FLUSH_ASID: flush_hit = (asid_q == flush_asid_i) && !g_q;
      FLUSH_PAGE: flush_hit = flush_match;
      default:    flush_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (op_i == OP_FLUSH && flush_hit) begin
      valid_q <= 1'b0;
    end else if (op_i == OP_FILL && write_i) begin
      valid_q <= 1'b1;
    end
  end

  // Translation payload, meaningful only while valid_q is set
  always_ff @(posedge clk_i) begin
    if (op_i == OP_FILL && write_i) begin
      vpn_q  <= fill_vpn_i;
      ppn_q  <= fill_ppn_i;
      asid_q <= asid_i;
      g_q    <= fill_g_i;
      u_q    <= fill_u_i;
      r_q    <= fill_r_i;
      w_q    <= fill_w_i;
      x_q    <= fill_x_i;
      d_q    <= fill_d_i;
      mebi_q <= (fill_page_i == PAGE_MEBI);
      gibi_q <= (fill_page_i == PAGE_GIBI);
    end
  end

  assign valid_o = valid_q;
  assign ppn_o   = ppn_q;

endmodule

// File: dtlb_pkg.sv
/* Sizes, field widths and shared enums of the Sv39 first-level data TLB.
   Imported by every RTL module and by the testbench. */

package dtlb_pkg;

  // TLB geometry
  localparam int TLB_ENTRIES  = 8;
  localparam int TLB_IDX_W    = $clog2(TLB_ENTRIES);

  // Pending-miss table geometry
  localparam int MSHR_ENTRIES = 4;
  localparam int MSHR_IDX_W   = $clog2(MSHR_ENTRIES);

  // Sv39 virtual page number, three 9-bit levels
  localparam int LEVEL_W = 9;
  localparam int VPN_W   = 3 * LEVEL_W;

  // Physical page number and address space id
  localparam int PPN_W  = 44;
  localparam int ASID_W = 16;

  // Privilege mode, encoded as in mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  // Kind of flush requested by sfence.vma
  typedef enum logic [1:0] {
    FLUSH_NONE,
    FLUSH_ALL,
    FLUSH_ASID,
    FLUSH_PAGE
  } flush_e;

  // Page size returned by the page walk
  typedef enum logic [1:0] {
    PAGE_KIBI,
    PAGE_MEBI,
    PAGE_GIBI
  } page_e;

  // Single operation granted to the entry array in a cycle
  typedef enum logic [1:0] {
    OP_IDLE,
    OP_FLUSH,
    OP_FILL,
    OP_LOOKUP
  } tlb_op_e;

endpackage
